// File: Makefile
VERILATOR ?= verilator
TOP       ?= gsim_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: logic/gsim_mem_reader.sv
// gsim memory reader: one outstanding read, returned word delivered as a tagged row beat
`default_nettype none

module gsim_mem_reader (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire gsim_pkg::mem_req_t i_req,
	output logic                    o_busy,
	output logic                    o_mem_rreq,
	output gsim_pkg::mem_addr_t     o_mem_addr,
	input  wire                     i_mem_rrdy,
	input  wire gsim_pkg::row_word_t i_mem_dout,
	input  wire                     i_mem_dout_vld,
	output gsim_pkg::row_beat_t     o_beat
);
	import gsim_pkg::*;

	localparam int N_MAT = 2 ** $bits(mat_idx_t);

	typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT} rd_state_e;

	rd_state_e rd_state;
	mem_addr_t addr_r;
	mem_addr_t mat_base;
	mem_addr_t offset;   // word position inside the matrix, 0..16
	row_word_t word_r;
	logic      beat_vld;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			rd_state <= RD_IDLE;
			beat_vld <= 1'b0;
		end else begin
			beat_vld <= 1'b0;
			case (rd_state)
				RD_IDLE: if (i_req.valid) rd_state <= RD_REQ;
				RD_REQ:  if (i_mem_rrdy) rd_state <= RD_WAIT;   // request taken
				RD_WAIT: begin
					if (i_mem_dout_vld) begin
						rd_state <= RD_IDLE;
						beat_vld <= 1'b1;
					end
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (rd_state == RD_IDLE && i_req.valid) addr_r <= i_req.addr;
		if (rd_state == RD_WAIT && i_mem_dout_vld) word_r <= i_mem_dout;
	end

	// largest matrix base not above the address
	always_comb begin
		mat_base = '0;
		for (int k = 1; k < N_MAT; k++) begin
			if (addr_r >= mem_addr_t'(ROWS_PER_MAT * k)) begin
				mat_base = mem_addr_t'(ROWS_PER_MAT * k);
			end
		end
		offset = addr_r - mat_base;
	end

	assign o_busy     = (rd_state != RD_IDLE);
	assign o_mem_rreq = (rd_state == RD_REQ);
	assign o_mem_addr = addr_r;
	assign o_beat     = '{valid: beat_vld, is_b: (offset == mem_addr_t'(N_UNK)),
		row: row_idx_t'(offset), word: word_r};

	a_addr_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_mem_rreq && !i_mem_rrdy |=> o_mem_rreq && $stable(o_mem_addr));

	a_no_stray_data: assert property (@(posedge i_clk) disable iff (i_reset)
		i_mem_dout_vld |-> rd_state == RD_WAIT);

endmodule

`default_nettype wire

// File: logic/gsim_pkg.sv
// gsim shared types: fixed-point formats, memory word layout, block interfaces
`default_nettype none

package gsim_pkg;

	// --------------------
	// problem geometry and number formats
	localparam int N_UNK        = 16;   // unknowns per system, also lanes per word
	localparam int ROWS_PER_MAT = 17;   // 16 rows of A then b
	localparam int RECIP_FRAC   = 14;   // 1/a_ii is Q2.14
	localparam int X_FRAC       = 16;   // x is Q16.16

	typedef logic signed [15:0] coef_t;
	typedef logic signed [31:0] fix_t;
	typedef logic signed [47:0] acc_t;   // row sum and scaled result

	typedef coef_t [N_UNK-1:0] row_word_t;   // lane j = column j
	typedef fix_t  [N_UNK-1:0] x_vec_t;

	typedef logic [9:0] mem_addr_t;
	typedef logic [8:0] x_addr_t;
	typedef logic [3:0] row_idx_t;
	typedef logic [4:0] mat_idx_t;

	localparam fix_t FIX_MAX = 32'sh7FFF_FFFF;
	localparam fix_t FIX_MIN = 32'sh8000_0000;

	// --------------------
	// block interfaces
	typedef struct packed {
		logic      valid;
		mem_addr_t addr;
	} mem_req_t;

	typedef struct packed {
		logic      valid;
		logic      is_b;   // word 16 of the matrix
		row_idx_t  row;
		row_word_t word;
	} row_beat_t;

	typedef struct packed {
		logic    wen;
		x_addr_t addr;
		fix_t    data;
	} x_write_t;

	typedef enum logic [2:0] {IDLE, LOAD_B, SWEEP, WRITE, FINISH} gs_state_e;

	// clamp a wide value into Q16.16 range
	function automatic fix_t sat32(input acc_t v);
		fix_t r;
		if (v > acc_t'(FIX_MAX)) r = FIX_MAX;
		else if (v < acc_t'(FIX_MIN)) r = FIX_MIN;
		else r = fix_t'(v);
		return r;
	endfunction

endpackage

`default_nettype wire

// File: logic/gsim_result_writer.sv
// gsim result writer: streams the 16 solved values of one matrix to the result port
`default_nettype none

module gsim_result_writer (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire                     i_start,
	input  wire gsim_pkg::mat_idx_t i_mat,
	input  wire gsim_pkg::x_vec_t   i_x,
	output gsim_pkg::x_write_t      o_write,
	output logic                    o_write_done
);
	import gsim_pkg::*;

	logic     active_r;
	row_idx_t idx_r;
	mat_idx_t mat_r;
	logic     wen_r;
	logic     done_r;
	x_addr_t  addr_r;
	fix_t     data_r;

	row_idx_t wr_idx;
	mat_idx_t wr_mat;
	logic     step;

	assign step   = i_start || active_r;
	assign wr_idx = i_start ? '0 : idx_r;
	assign wr_mat = i_start ? i_mat : mat_r;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			active_r <= 1'b0;
			idx_r    <= '0;
			wen_r    <= 1'b0;
			done_r   <= 1'b0;
		end else begin
			wen_r    <= step;
			done_r   <= active_r && !i_start && (idx_r == 4'd15);   // with the last write
			active_r <= i_start || (active_r && idx_r != 4'd15);
			if (step) idx_r <= wr_idx + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) mat_r <= i_mat;
		if (step) begin
			addr_r <= {wr_mat, wr_idx};   // 16 * matrix + index
			data_r <= i_x[wr_idx];
		end
	end

	assign o_write      = '{wen: wen_r, addr: addr_r, data: data_r};
	assign o_write_done = done_r;

endmodule

`default_nettype wire

// File: logic/gsim_row_solver.sv
// gsim row solver: holds x and applies one Gauss-Seidel row update per beat
`default_nettype none

module gsim_row_solver (
	input  wire                      i_clk,
	input  wire                      i_reset,
	input  wire gsim_pkg::row_beat_t i_beat,
	output gsim_pkg::x_vec_t         o_x,
	output logic                     o_sweep_stable
);
	import gsim_pkg::*;

	x_vec_t    x_r;
	row_word_t b_r;
	logic      stable_r;
	logic      b_seen;   // a b word has been loaded since reset

	acc_t row_sum;
	acc_t diff;
	acc_t scaled;
	fix_t x_new;
	logic row_beat;
	logic x_same;

	// --------------------
	// row arithmetic
	always_comb begin
		row_sum = '0;
		for (int j = 0; j < N_UNK; j++) begin
			if (j != int'(i_beat.row)) begin
				row_sum += acc_t'(i_beat.word[j]) * acc_t'(x_r[j]);   // integer * Q16.16
			end
		end
		diff = (acc_t'(b_r[i_beat.row]) <<< X_FRAC) - row_sum;
		// residual clamped to Q16.16 first, so the product stays inside acc_t
		scaled = (acc_t'(sat32(diff)) * acc_t'(i_beat.word[i_beat.row])) >>> RECIP_FRAC;
		x_new  = sat32(scaled);
	end

	assign row_beat = i_beat.valid && !i_beat.is_b;
	assign x_same   = (x_new == x_r[i_beat.row]);

	// --------------------
	// state
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			stable_r <= 1'b0;
			b_seen   <= 1'b0;
		end else begin
			if (i_beat.valid && i_beat.is_b) begin
				b_seen <= 1'b1;
			end
			if (row_beat) begin
				if (i_beat.row == '0) stable_r <= x_same;   // new sweep
				else if (!x_same) stable_r <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_beat.valid && i_beat.is_b) begin
			b_r <= i_beat.word;
			x_r <= '0;   // every matrix starts from zero
		end else if (row_beat) begin
			x_r[i_beat.row] <= x_new;
		end
	end

	assign o_x            = x_r;
	assign o_sweep_stable = stable_r;

	a_b_first: assert property (@(posedge i_clk) disable iff (i_reset)
		i_beat.valid && !i_beat.is_b |-> b_seen);

endmodule

`default_nettype wire

// File: logic/gsim_sequencer.sv
// gsim sequencer: FSM and matrix, sweep and row counters ordering reads, updates and writes
`default_nettype none

module gsim_sequencer #(
	parameter int MAX_ITER = 16
) (
	input  wire                      i_clk,
	input  wire                      i_reset,
	input  wire                      i_module_en,
	input  wire gsim_pkg::mat_idx_t  i_matrix_num,
	input  wire gsim_pkg::row_beat_t i_beat,
	input  wire                      i_reader_busy,
	input  wire                      i_sweep_stable,
	input  wire                      i_write_done,
	output gsim_pkg::mem_req_t       o_req,
	output logic                     o_write_start,
	output gsim_pkg::mat_idx_t       o_write_mat,
	output logic                     o_proc_done
);
	import gsim_pkg::*;

	localparam int SW_W = $clog2(MAX_ITER + 1);

	gs_state_e       state_r;
	mat_idx_t        mat_r;
	row_idx_t        row_r;     // next row to read
	logic [SW_W-1:0] sweep_r;   // sweeps started on this matrix
	logic            issue_r;   // a read is owed to the reader
	logic            eval_r;    // row 15 done, stability flag valid now

	mem_addr_t mat_base;
	mem_addr_t req_addr;
	logic      stop_now;
	logic      req_go;

	assign mat_base = (mem_addr_t'(mat_r) << 4) + mem_addr_t'(mat_r);   // 17 * matrix
	assign req_addr = mat_base + ((state_r == LOAD_B) ? mem_addr_t'(ROWS_PER_MAT - 1)
		: mem_addr_t'(row_r));

	assign stop_now = i_sweep_stable || (sweep_r == SW_W'(MAX_ITER));
	// the next sweep's row 0 goes out in the same cycle as the decision
	assign req_go   = (issue_r || (eval_r && !stop_now)) && !i_reader_busy;

	assign o_req         = '{valid: req_go, addr: req_addr};
	assign o_write_start = eval_r && stop_now;
	assign o_write_mat   = mat_r;
	assign o_proc_done   = (state_r == FINISH);

	// --------------------
	// FSM
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			state_r <= IDLE;
			mat_r   <= '0;
			row_r   <= '0;
			sweep_r <= '0;
			issue_r <= 1'b0;
			eval_r  <= 1'b0;
		end else begin
			eval_r <= 1'b0;
			if (req_go) issue_r <= 1'b0;
			case (state_r)
				IDLE: begin
					if (i_module_en) begin
						state_r <= LOAD_B;
						mat_r   <= '0;
						issue_r <= 1'b1;
					end
				end
				LOAD_B: begin
					if (i_beat.valid && i_beat.is_b) begin
						state_r <= SWEEP;
						row_r   <= '0;
						sweep_r <= SW_W'(1);
						issue_r <= 1'b1;
					end
				end
				SWEEP: begin
					if (eval_r) begin
						if (stop_now) begin
							state_r <= WRITE;
						end else begin
							sweep_r <= sweep_r + 1'b1;
							issue_r <= i_reader_busy;   // retry if not taken
						end
					end else if (i_beat.valid && !i_beat.is_b) begin
						row_r <= i_beat.row + 1'b1;   // wraps to 0 after row 15
						if (i_beat.row == 4'd15) eval_r <= 1'b1;
						else issue_r <= 1'b1;
					end
				end
				WRITE: begin
					if (i_write_done) begin
						if (mat_r == i_matrix_num - 5'd1) begin
							state_r <= FINISH;
						end else begin
							mat_r   <= mat_r + 1'b1;
							state_r <= LOAD_B;
							issue_r <= 1'b1;
						end
					end
				end
				FINISH: if (!i_module_en) state_r <= IDLE;
				default: state_r <= IDLE;
			endcase
		end
	end

	a_sweep_limit: assert property (@(posedge i_clk) disable iff (i_reset)
		sweep_r <= SW_W'(MAX_ITER));

endmodule

`default_nettype wire

// File: logic/gsim_top.sv
// gsim top: fixed-point Gauss-Seidel solver over a matrix memory
`default_nettype none

module gsim_top #(
	parameter int MAX_ITER = 16   // sweep limit per matrix
) (
	input  wire                      i_clk,
	input  wire                      i_reset,
	input  wire                      i_module_en,
	input  wire gsim_pkg::mat_idx_t  i_matrix_num,
	output logic                     o_proc_done,
	output logic                     o_mem_rreq,
	output gsim_pkg::mem_addr_t      o_mem_addr,
	input  wire                      i_mem_rrdy,
	input  wire gsim_pkg::row_word_t i_mem_dout,
	input  wire                      i_mem_dout_vld,
	output logic                     o_x_wen,
	output gsim_pkg::x_addr_t        o_x_addr,
	output gsim_pkg::fix_t           o_x_data
);
	import gsim_pkg::*;

	mem_req_t  req;
	logic      reader_busy;
	row_beat_t beat;
	x_vec_t    x_vec;
	logic      sweep_stable;
	logic      write_start;
	mat_idx_t  write_mat;
	logic      write_done;
	x_write_t  x_write;

	// --------------------
	// datapath blocks
	gsim_mem_reader u_reader (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_req          (req),
		.o_busy         (reader_busy),
		.o_mem_rreq     (o_mem_rreq),
		.o_mem_addr     (o_mem_addr),
		.i_mem_rrdy     (i_mem_rrdy),
		.i_mem_dout     (i_mem_dout),
		.i_mem_dout_vld (i_mem_dout_vld),
		.o_beat         (beat)
	);

	gsim_row_solver u_solver (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_beat         (beat),
		.o_x            (x_vec),
		.o_sweep_stable (sweep_stable)
	);

	gsim_sequencer #(
		.MAX_ITER (MAX_ITER)
	) u_sequencer (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_module_en    (i_module_en),
		.i_matrix_num   (i_matrix_num),
		.i_beat         (beat),
		.i_reader_busy  (reader_busy),
		.i_sweep_stable (sweep_stable),
		.i_write_done   (write_done),
		.o_req          (req),
		.o_write_start  (write_start),
		.o_write_mat    (write_mat),
		.o_proc_done    (o_proc_done)
	);

	gsim_result_writer u_writer (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_start      (write_start),
		.i_mat        (write_mat),
		.i_x          (x_vec),
		.o_write      (x_write),
		.o_write_done (write_done)
	);

	// result port
	assign o_x_wen  = x_write.wen;
	assign o_x_addr = x_write.addr;
	assign o_x_data = x_write.data;

endmodule

`default_nettype wire

// File: sim.f
logic/gsim_pkg.sv
logic/gsim_mem_reader.sv
logic/gsim_row_solver.sv
logic/gsim_sequencer.sv
logic/gsim_result_writer.sv
logic/gsim_top.sv
verification/gsim_mem_model.sv
verification/gsim_tb.sv

// File: verification/gsim_mem_model.sv
// gsim memory model: matrix word store with random ready and random return delay
`default_nettype none

module gsim_mem_model (
	input  wire                      i_clk,
	input  wire                      i_reset,
	input  wire                      i_rreq,
	input  wire gsim_pkg::mem_addr_t i_addr,
	output logic                     o_rrdy,
	output gsim_pkg::row_word_t      o_dout,
	output logic                     o_dout_vld
);
	import gsim_pkg::*;

	row_word_t mem [0:1023];
	integer    seed = 96;
	mem_addr_t addr_q;
	logic      pending;   // a read was taken and its word is still owed
	int        delay;

	// distinct pattern per address, so a wrong read shows up
	initial begin
		for (int a = 0; a < 1024; a++) begin
			for (int j = 0; j < N_UNK; j++) begin
				mem[a][j] = coef_t'(a * N_UNK + j);
			end
		end
	end

	task automatic load_word(input mem_addr_t addr, input row_word_t word);
		mem[addr] = word;
	endtask

	// outputs change on the falling edge only
	always @(negedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			o_rrdy     = 1'b0;
			o_dout     = '0;
			o_dout_vld = 1'b0;
			pending    = 1'b0;
			delay      = 0;
		end else begin
			o_dout_vld = 1'b0;
			if (pending) begin
				if (delay == 0) begin
					o_dout_vld = 1'b1;
					o_dout     = mem[addr_q];
					pending    = 1'b0;
				end else begin
					delay = delay - 1;
				end
			end
			o_rrdy = ($random(seed) & 3) != 0;   // ready about 3 cycles in 4
			if (i_rreq && o_rrdy) begin
				// taken at the coming rising edge
				addr_q  = i_addr;
				pending = 1'b1;
				delay   = $random(seed) & 3;
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/gsim_tb.sv
// gsim testbench: directed tests of the Gauss-Seidel solver against a reference model
`default_nettype none

module gsim_tb;
	import gsim_pkg::*;

	localparam int MAX_ITER  = 16;
	localparam int TOTAL_MAT = 6;   // matrices solved over all tests
	localparam int CYC_LIMIT = 40 * (TOTAL_MAT * MAX_ITER * ROWS_PER_MAT * 6
		+ TOTAL_MAT * N_UNK);

	logic      clk = 1'b0;
	logic      reset;
	logic      module_en;
	mat_idx_t  matrix_num;
	logic      proc_done;
	logic      mem_rreq;
	mem_addr_t mem_addr;
	logic      mem_rrdy;
	row_word_t mem_dout;
	logic      mem_dout_vld;
	logic      x_wen;
	x_addr_t   x_addr;
	fix_t      x_data;

	row_word_t img [0:1023];   // words loaded for the current test
	fix_t      exp_x [0:511];
	fix_t      got_x [0:511];
	int        hits [0:511];
	int        n_writes;
	int        late_writes;    // writes seen while o_proc_done high
	int        errors;
	int        failed_tests;
	int        n_tests;
	int        cycles = 0;
	integer    seed = 96;

	gsim_top #(
		.MAX_ITER (MAX_ITER)
	) uut (
		.i_clk          (clk),
		.i_reset        (reset),
		.i_module_en    (module_en),
		.i_matrix_num   (matrix_num),
		.o_proc_done    (proc_done),
		.o_mem_rreq     (mem_rreq),
		.o_mem_addr     (mem_addr),
		.i_mem_rrdy     (mem_rrdy),
		.i_mem_dout     (mem_dout),
		.i_mem_dout_vld (mem_dout_vld),
		.o_x_wen        (x_wen),
		.o_x_addr       (x_addr),
		.o_x_data       (x_data)
	);

	gsim_mem_model mem_model (
		.i_clk      (clk),
		.i_reset    (reset),
		.i_rreq     (mem_rreq),
		.i_addr     (mem_addr),
		.o_rrdy     (mem_rrdy),
		.o_dout     (mem_dout),
		.o_dout_vld (mem_dout_vld)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > CYC_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	// result port capture, one write per cycle
	always @(negedge clk) begin
		if (!reset && x_wen) begin
			got_x[x_addr] = x_data;
			hits[x_addr]  = hits[x_addr] + 1;
			n_writes      = n_writes + 1;
			if (proc_done) late_writes = late_writes + 1;
		end
	end

	// --------------------
	// reference model
	function automatic longint clamp_q16(input longint v);
		longint r;
		r = v;
		if (v > 64'sd2147483647) r = 64'sd2147483647;
		if (v < -64'sd2147483648) r = -64'sd2147483648;
		return r;
	endfunction

	task automatic solve_ref(input int m);
		longint    x [N_UNK];
		longint    sum;
		longint    resid;
		longint    nv;
		row_word_t row;
		row_word_t bv;
		bit        changed;
		int        sweep;
		for (int i = 0; i < N_UNK; i++) x[i] = 0;
		bv    = img[ROWS_PER_MAT * m + N_UNK];
		sweep = 0;
		do begin
			changed = 1'b0;
			sweep++;
			for (int i = 0; i < N_UNK; i++) begin
				row = img[ROWS_PER_MAT * m + i];
				sum = 0;
				for (int j = 0; j < N_UNK; j++) begin
					if (j != i) sum += longint'(row[j]) * x[j];
				end
				resid = clamp_q16((longint'(bv[i]) <<< X_FRAC) - sum);
				nv    = clamp_q16((resid * longint'(row[i])) >>> RECIP_FRAC);
				if (nv != x[i]) changed = 1'b1;
				x[i] = nv;   // later rows see it in this sweep
			end
		end while (changed && sweep < MAX_ITER);
		for (int i = 0; i < N_UNK; i++) exp_x[N_UNK * m + i] = fix_t'(x[i]);
	endtask

	// --------------------
	// helpers
	task automatic put_word(input int addr, input row_word_t word);
		img[addr] = word;
		mem_model.load_word(mem_addr_t'(addr), word);
	endtask

	task automatic load_dense(input int m);
		row_word_t w;
		int        a_ii;
		for (int i = 0; i < N_UNK; i++) begin
			for (int j = 0; j < N_UNK; j++) w[j] = coef_t'($random(seed) % 4);
			a_ii = 64 + ($random(seed) & 63);   // dominates the 15 small lanes
			w[i] = coef_t'(16384 / a_ii);
			put_word(ROWS_PER_MAT * m + i, w);
		end
		for (int j = 0; j < N_UNK; j++) w[j] = coef_t'($random(seed) % 1000);
		put_word(ROWS_PER_MAT * m + N_UNK, w);
		solve_ref(m);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic run_solver(input int nmat);
		for (int a = 0; a < 512; a++) hits[a] = 0;
		n_writes    = 0;
		late_writes = 0;
		@(negedge clk);
		matrix_num = mat_idx_t'(nmat);
		module_en  = 1'b1;
		while (!proc_done) @(negedge clk);
		assert (n_writes == N_UNK * nmat) else begin
			$display("error at %0t: done rose after %0d of %0d writes", $time, n_writes,
				N_UNK * nmat);
			errors++;
		end
		repeat (4) begin
			@(negedge clk);
			check_bit("o_proc_done", proc_done, 1'b1);
		end
		module_en = 1'b0;
		@(negedge clk);
		check_bit("o_proc_done", proc_done, 1'b0);   // one cycle after enable drops
		assert (late_writes == 0) else begin
			$display("error at %0t: %0d writes came after done", $time, late_writes);
			errors++;
		end
		@(negedge clk);
	endtask

	task automatic check_results(input int nmat);
		int addr;
		for (int m = 0; m < nmat; m++) begin
			for (int i = 0; i < N_UNK; i++) begin
				addr = N_UNK * m + i;
				assert (hits[addr] == 1) else begin
					$display("error at %0t: address %0d written %0d times", $time, addr,
						hits[addr]);
					errors++;
				end
				assert (got_x[addr] === exp_x[addr]) else begin
					$display("mismatch at %0t: o_x_data[%0d] got %h expected %h", $time, addr,
						got_x[addr], exp_x[addr]);
					errors++;
				end
			end
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		n_tests++;
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	// --------------------
	// directed tests
	task automatic test_reset();
		int e0;
		e0 = errors;
		check_bit("o_proc_done", proc_done, 1'b0);
		check_bit("o_mem_rreq", mem_rreq, 1'b0);
		check_bit("o_x_wen", x_wen, 1'b0);
		report_test("reset state", e0);
	endtask

	task automatic test_diagonal();
		row_word_t w;
		row_word_t bv;
		int        e0;
		e0 = errors;
		for (int i = 0; i < N_UNK; i++) begin
			w    = '0;
			w[i] = coef_t'(16384 / (i + 3));
			put_word(i, w);
		end
		for (int j = 0; j < N_UNK; j++) bv[j] = coef_t'(j * 211 - 1500);
		put_word(N_UNK, bv);
		// no coupling, so x_i is b_i times 1/a_ii
		for (int i = 0; i < N_UNK; i++) begin
			exp_x[i] = fix_t'(clamp_q16(((longint'(bv[i]) <<< X_FRAC)
				* longint'(16384 / (i + 3))) >>> RECIP_FRAC));
		end
		run_solver(1);
		check_results(1);
		report_test("diagonal system", e0);
	endtask

	task automatic test_dense();
		int e0;
		e0 = errors;
		load_dense(0);
		run_solver(1);
		check_results(1);
		report_test("dense system", e0);
	endtask

	task automatic test_saturation();
		row_word_t w;
		row_word_t bv;
		int        e0;
		e0 = errors;
		for (int i = 0; i < N_UNK; i++) begin
			w    = '0;
			w[i] = coef_t'(16'h7FFF);   // reciprocal just under 2.0
			put_word(i, w);
		end
		for (int j = 0; j < N_UNK; j++) begin
			case (j % 4)
				0:       bv[j] = coef_t'(32767);
				1:       bv[j] = coef_t'(-32768);
				default: bv[j] = coef_t'(j * 50 - 400);
			endcase
		end
		put_word(N_UNK, bv);
		solve_ref(0);
		run_solver(1);
		check_results(1);
		for (int i = 0; i < N_UNK; i += 4) begin
			assert (got_x[i] === 32'sh7FFF_FFFF && got_x[i + 1] === 32'sh8000_0000) else begin
				$display("mismatch at %0t: o_x_data[%0d..%0d] got %h %h expected 7fffffff 80000000",
					$time, i, i + 1, got_x[i], got_x[i + 1]);
				errors++;
			end
		end
		report_test("saturation", e0);
	endtask

	task automatic test_multi();
		int e0;
		e0 = errors;
		for (int m = 0; m < 3; m++) load_dense(m);
		run_solver(3);
		check_results(3);
		report_test("multiple matrices", e0);
	endtask

	initial begin
		reset        = 1'b1;
		module_en    = 1'b0;
		matrix_num   = '0;
		errors       = 0;
		failed_tests = 0;
		n_tests      = 0;
		n_writes     = 0;
		late_writes  = 0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		test_reset();
		test_diagonal();
		test_dense();
		test_saturation();
		test_multi();
		$display("tests run %0d, failed %0d, errors %0d", n_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
